//--- fm_core_top.sv
// top level of the fm register core
// host port, timebase, parameter bus arbiter, parameter memory and slot sequencer
`timescale 1ns/1ps

module fm_core_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [1:0]             addr,
	input  logic [7:0]             din,
	input  logic                   write,
	output logic                   busy,
	output logic                   irq,
	output logic                   flag_a,
	output logic                   flag_b,
	output fm_reg_pkg::fm_global_t glob,
	output fm_param_pkg::fm_slot_t slot,
	output logic                   slot_valid
);

	fm_reg_pkg::fm_timer_ctrl_t         tctrl;
	logic [fm_param_pkg::NUM_SLOTS-1:0] keyon;
	logic                               tick;
	fm_param_pkg::fm_wb_req_t           host_req;
	fm_param_pkg::fm_wb_rsp_t           host_rsp;
	fm_param_pkg::fm_wb_req_t           seq_req;
	fm_param_pkg::fm_wb_rsp_t           seq_rsp;
	fm_param_pkg::fm_wb_req_t           mem_req;
	fm_param_pkg::fm_wb_rsp_t           mem_rsp;

	fm_host_port fm_host_port_inst (
		.clk    (clk),
		.rst    (rst),
		.addr   (addr),
		.din    (din),
		.write  (write),
		.busy   (busy),
		.glob   (glob),
		.tctrl  (tctrl),
		.keyon  (keyon),
		.wb_req (host_req),
		.wb_rsp (host_rsp)
	);

	fm_timebase fm_timebase_inst (
		.clk    (clk),
		.rst    (rst),
		.tctrl  (tctrl),
		.tick   (tick),
		.flag_a (flag_a),
		.flag_b (flag_b),
		.irq    (irq)
	);

	fm_param_arbiter fm_param_arbiter_inst (
		.clk      (clk),
		.rst      (rst),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.seq_req  (seq_req),
		.seq_rsp  (seq_rsp),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

	fm_param_ram fm_param_ram_inst (
		.clk    (clk),
		.rst    (rst),
		.wb_req (mem_req),
		.wb_rsp (mem_rsp)
	);

	fm_slot_seq fm_slot_seq_inst (
		.clk        (clk),
		.rst        (rst),
		.tick       (tick),
		.keyon      (keyon),
		.wb_req     (seq_req),
		.wb_rsp     (seq_rsp),
		.slot       (slot),
		.slot_valid (slot_valid)
	);

endmodule

//--- fm_host_port.sv
// host address/data port of the fm core
// keeps the global registers and forwards channel/operator writes over wishbone
`timescale 1ns/1ps

module fm_host_port (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [1:0]                            addr,
	input  logic [7:0]                            din,
	input  logic                                  write,
	output logic                                  busy,
	output fm_reg_pkg::fm_global_t                glob,
	output fm_reg_pkg::fm_timer_ctrl_t            tctrl,
	output logic [fm_param_pkg::NUM_SLOTS-1:0]    keyon,
	output fm_param_pkg::fm_wb_req_t              wb_req,
	input  fm_param_pkg::fm_wb_rsp_t              wb_rsp
);

	typedef enum logic {
		HOST_IDLE,
		HOST_WRITE
	} host_state_e;

	host_state_e               state;
	fm_reg_pkg::fm_reg_group_e grp;
	logic                      write_q;
	logic                      accept;
	logic [7:0]                sel_reg;
	logic                      bank;
	logic [2:0]                kon_ch;
	logic                      kon_valid;

	// new write on a rising edge of write and ignored while busy
	assign accept = write && !write_q && !busy;
	assign busy   = (state == HOST_WRITE);

	// din[2] picks the upper channel triple and codes 3 and 7 are unused
	assign kon_valid = (din[1:0] != 2'b11);
	assign kon_ch    = din[2] ? 3'(din[1:0]) + 3'd3 : 3'(din[1:0]);

	always_comb begin
		if (sel_reg < fm_reg_pkg::REG_OP_DT1MUL)
			grp = fm_reg_pkg::GRP_GLOBAL;
		else if (sel_reg[1:0] == 2'b11 || sel_reg > 8'hB6)
			grp = fm_reg_pkg::GRP_NONE;
		else if (sel_reg < fm_reg_pkg::REG_CH_FNUM_LO)
			grp = fm_reg_pkg::GRP_OPERATOR;
		else
			grp = fm_reg_pkg::GRP_CHANNEL;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			write_q <= 1'b0;
			sel_reg <= 8'h00;
			bank    <= 1'b0;
			glob    <= '0;
			tctrl   <= '0;
			keyon   <= '0;
		end else begin
			write_q     <= write;
			// flag clears are single-cycle requests
			tctrl.clr_a <= 1'b0;
			tctrl.clr_b <= 1'b0;
			if (accept && !addr[0]) begin
				sel_reg <= din;
				bank    <= addr[1];
			end else if (accept && grp == fm_reg_pkg::GRP_GLOBAL) begin
				case (sel_reg)
					fm_reg_pkg::REG_LFO:     {glob.lfo_en, glob.lfo_freq} <= din[3:0];
					fm_reg_pkg::REG_CLKA1:   tctrl.value_a[9:2] <= din;
					fm_reg_pkg::REG_CLKA2:   tctrl.value_a[1:0] <= din[1:0];
					fm_reg_pkg::REG_CLKB:    tctrl.value_b <= din;
					fm_reg_pkg::REG_TIMER: begin
						{tctrl.clr_b, tctrl.clr_a} <= din[5:4];
						{tctrl.irq_en_b, tctrl.irq_en_a} <= din[3:2];
						{tctrl.load_b, tctrl.load_a} <= din[1:0];
					end
					fm_reg_pkg::REG_KON: begin
						// din[7:4] carries one key bit per operator
						if (kon_valid) begin
							for (int o = 0; o < fm_param_pkg::NUM_OP; o++)
								keyon[o * fm_param_pkg::NUM_CH + kon_ch] <= din[4 + o];
						end
					end
					fm_reg_pkg::REG_PCM:     glob.pcm[8:1] <= din;
					fm_reg_pkg::REG_PCM_EN:  glob.pcm_en <= din[7];
					fm_reg_pkg::REG_DACTEST: glob.pcm[0] <= din[3];
					fm_reg_pkg::REG_CLK_N6:  tctrl.presc <= fm_reg_pkg::PRESC_6;
					fm_reg_pkg::REG_CLK_N3:  tctrl.presc <= fm_reg_pkg::PRESC_3;
					fm_reg_pkg::REG_CLK_N2:  tctrl.presc <= fm_reg_pkg::PRESC_2;
					default: ;
				endcase
			end
		end
	end

	// parameter memory write, one byte per host data write
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= HOST_IDLE;
			wb_req.cyc <= 1'b0;
			wb_req.stb <= 1'b0;
			wb_req.we  <= 1'b0;
		end else begin
			case (state)
				HOST_IDLE: begin
					if (accept && addr[0] && (grp == fm_reg_pkg::GRP_OPERATOR ||
						grp == fm_reg_pkg::GRP_CHANNEL)) begin
						state      <= HOST_WRITE;
						wb_req.cyc <= 1'b1;
						wb_req.stb <= 1'b1;
						wb_req.we  <= 1'b1;
					end
				end
				HOST_WRITE: begin
					if (wb_rsp.ack) begin
						state      <= HOST_IDLE;
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						wb_req.we  <= 1'b0;
					end
				end
				default: state <= HOST_IDLE;
			endcase
		end
	end

	// address and data are captured with the request
	always_ff @(posedge clk) begin
		if (state == HOST_IDLE && accept && addr[0]) begin
			wb_req.adr <= {bank, sel_reg};
			wb_req.dat <= din;
		end
	end

	// bus cycle and busy cover the same clocks and every ack falls inside the cycle
	a_cyc_busy: assert property (@(posedge clk) disable iff (rst)
		(wb_req.cyc == busy) && (!wb_rsp.ack || wb_req.cyc));

endmodule

//--- fm_param_arbiter.sv
// round-robin wishbone classic arbiter
// joins the host port and the slot sequencer onto the parameter memory
`timescale 1ns/1ps

module fm_param_arbiter (
	input  logic                     clk,
	input  logic                     rst,
	input  fm_param_pkg::fm_wb_req_t host_req,
	output fm_param_pkg::fm_wb_rsp_t host_rsp,
	input  fm_param_pkg::fm_wb_req_t seq_req,
	output fm_param_pkg::fm_wb_rsp_t seq_rsp,
	output fm_param_pkg::fm_wb_req_t mem_req,
	input  fm_param_pkg::fm_wb_rsp_t mem_rsp
);

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_HOST,
		GNT_SEQ
	} gnt_e;

	gnt_e gnt;
	logic last_seq;

	always_ff @(posedge clk) begin
		if (rst) begin
			gnt      <= GNT_NONE;
			last_seq <= 1'b0;
		end else begin
			case (gnt)
				GNT_NONE: begin
					// the host wins a tie only when the sequencer went last
					if (host_req.cyc && (!seq_req.cyc || last_seq))
						gnt <= GNT_HOST;
					else if (seq_req.cyc)
						gnt <= GNT_SEQ;
				end
				GNT_HOST: begin
					if (!host_req.cyc) begin
						gnt      <= GNT_NONE;
						last_seq <= 1'b0;
					end
				end
				GNT_SEQ: begin
					if (!seq_req.cyc) begin
						gnt      <= GNT_NONE;
						last_seq <= 1'b1;
					end
				end
				default: gnt <= GNT_NONE;
			endcase
		end
	end

	always_comb begin
		case (gnt)
			GNT_HOST: mem_req = host_req;
			GNT_SEQ:  mem_req = seq_req;
			default:  mem_req = '0;
		endcase
		host_rsp.dat = mem_rsp.dat;
		host_rsp.ack = mem_rsp.ack && (gnt == GNT_HOST);
		seq_rsp.dat  = mem_rsp.dat;
		seq_rsp.ack  = mem_rsp.ack && (gnt == GNT_SEQ);
	end

	// an ack only returns to a master that held the grant through its access
	a_ack_owner: assert property (@(posedge clk) disable iff (rst)
		mem_rsp.ack |-> (gnt != GNT_NONE && gnt == $past(gnt)));

endmodule

//--- fm_param_pkg.sv
// parameter memory bus and voice slot definitions
// wishbone request/response structs, address layout and the slot record
package fm_param_pkg;

	localparam int NUM_CH    = 6;
	localparam int NUM_OP    = 4;
	localparam int NUM_SLOTS = 24;

	// bank bit followed by the register byte
	localparam int PADDR_W = 9;

	typedef struct packed {
		logic               cyc;
		logic               stb;
		logic               we;
		logic [PADDR_W-1:0] adr;
		logic [7:0]         dat;
	} fm_wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} fm_wb_rsp_t;

	typedef struct packed {
		logic [2:0]  ch;
		logic [1:0]  op;
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  dt1;
		logic [3:0]  mul;
		logic [6:0]  tl;
		logic        keyon;
	} fm_slot_t;

endpackage

//--- fm_param_ram.sv
// wishbone classic slave with 512 bytes of channel/operator parameters
`timescale 1ns/1ps

module fm_param_ram (
	input  logic                     clk,
	input  logic                     rst,
	input  fm_param_pkg::fm_wb_req_t wb_req,
	output fm_param_pkg::fm_wb_rsp_t wb_rsp
);

	logic [7:0] mem [0:(1 << fm_param_pkg::PADDR_W) - 1];
	logic       access;

	// the !ack term keeps a held request from being served twice
	assign access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

	always_ff @(posedge clk) begin
		if (rst)
			wb_rsp.ack <= 1'b0;
		else
			wb_rsp.ack <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (wb_req.we)
				mem[wb_req.adr] <= wb_req.dat;
			else
				wb_rsp.dat <= mem[wb_req.adr];
		end
	end

	// the master still holds its request in the ack clock
	a_ack_req: assert property (@(posedge clk) disable iff (rst)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb) && wb_req.cyc && wb_req.stb);

endmodule

//--- fm_reg_pkg.sv
// host register map of the fm sound generator
// global register addresses, register groups, timer control and global outputs
package fm_reg_pkg;

	// global registers
	localparam logic [7:0] REG_LFO     = 8'h22;
	localparam logic [7:0] REG_CLKA1   = 8'h24;
	localparam logic [7:0] REG_CLKA2   = 8'h25;
	localparam logic [7:0] REG_CLKB    = 8'h26;
	localparam logic [7:0] REG_TIMER   = 8'h27;
	localparam logic [7:0] REG_KON     = 8'h28;
	localparam logic [7:0] REG_PCM     = 8'h2A;
	localparam logic [7:0] REG_PCM_EN  = 8'h2B;
	localparam logic [7:0] REG_DACTEST = 8'h2C;
	localparam logic [7:0] REG_CLK_N6  = 8'h2D;
	localparam logic [7:0] REG_CLK_N3  = 8'h2E;
	localparam logic [7:0] REG_CLK_N2  = 8'h2F;

	// operator and channel register bases
	localparam logic [7:0] REG_OP_DT1MUL  = 8'h30;
	localparam logic [7:0] REG_OP_TL      = 8'h40;
	localparam logic [7:0] REG_CH_FNUM_LO = 8'hA0;
	localparam logic [7:0] REG_CH_FNUM_HI = 8'hA4;

	typedef enum logic [1:0] {
		GRP_GLOBAL,
		GRP_OPERATOR,
		GRP_CHANNEL,
		GRP_NONE
	} fm_reg_group_e;

	typedef enum logic [1:0] {
		PRESC_6,
		PRESC_3,
		PRESC_2
	} fm_presc_e;

	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       irq_en_a;
		logic       irq_en_b;
		logic       clr_a;
		logic       clr_b;
		fm_presc_e  presc;
	} fm_timer_ctrl_t;

	typedef struct packed {
		logic       lfo_en;
		logic [2:0] lfo_freq;
		logic [8:0] pcm;
		logic       pcm_en;
	} fm_global_t;

endpackage

//--- fm_slot_seq.sv
// slot sequencer that reads four parameter bytes per slot and emits slot records
`timescale 1ns/1ps

module fm_slot_seq (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               tick,
	input  logic [fm_param_pkg::NUM_SLOTS-1:0] keyon,
	output fm_param_pkg::fm_wb_req_t           wb_req,
	input  fm_param_pkg::fm_wb_rsp_t           wb_rsp,
	output fm_param_pkg::fm_slot_t             slot,
	output logic                               slot_valid
);

	typedef enum logic [1:0] {
		SEQ_WAIT,
		SEQ_READ,
		SEQ_EMIT
	} seq_state_e;

	seq_state_e state;
	logic [2:0] ch;
	logic [1:0] op;
	logic [1:0] idx;
	logic       bank;
	logic [1:0] sub;
	logic [7:0] reg_byte;
	logic [4:0] slot_idx;

	// channels 3 to 5 sit in the upper bank
	assign bank     = (ch >= 3'd3);
	assign sub      = bank ? 2'(ch - 3'd3) : ch[1:0];
	assign slot_idx = 5'(op) * 5'(fm_param_pkg::NUM_CH) + 5'(ch);

	always_comb begin
		case (idx)
			2'd0:    reg_byte = fm_reg_pkg::REG_OP_TL + 8'({op, 2'b00}) + 8'(sub);
			2'd1:    reg_byte = fm_reg_pkg::REG_OP_DT1MUL + 8'({op, 2'b00}) + 8'(sub);
			2'd2:    reg_byte = fm_reg_pkg::REG_CH_FNUM_LO + 8'(sub);
			default: reg_byte = fm_reg_pkg::REG_CH_FNUM_HI + 8'(sub);
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= SEQ_WAIT;
			ch         <= 3'd0;
			op         <= 2'd0;
			idx        <= 2'd0;
			wb_req.cyc <= 1'b0;
			wb_req.stb <= 1'b0;
			wb_req.we  <= 1'b0;
			slot_valid <= 1'b0;
		end else begin
			slot_valid <= 1'b0;
			case (state)
				SEQ_WAIT: begin
					if (tick) begin
						state   <= SEQ_READ;
						idx     <= 2'd0;
						slot.ch <= ch;
						slot.op <= op;
					end
				end
				SEQ_READ: begin
					if (wb_rsp.ack) begin
						// drop cyc for a cycle between reads
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						case (idx)
							2'd0: slot.tl <= wb_rsp.dat[6:0];
							2'd1: {slot.dt1, slot.mul} <= wb_rsp.dat[6:0];
							2'd2: slot.fnum[7:0] <= wb_rsp.dat;
							default: {slot.block, slot.fnum[10:8]} <= wb_rsp.dat[5:0];
						endcase
						idx <= idx + 2'd1;
						if (idx == 2'd3)
							state <= SEQ_EMIT;
					end else if (!wb_req.cyc) begin
						wb_req.cyc <= 1'b1;
						wb_req.stb <= 1'b1;
						wb_req.we  <= 1'b0;
						wb_req.adr <= {bank, reg_byte};
						wb_req.dat <= 8'h00;
					end
				end
				SEQ_EMIT: begin
					slot.keyon <= keyon[slot_idx];
					slot_valid <= 1'b1;
					state      <= SEQ_WAIT;
					// channel order inside each operator
					if (ch == 3'(fm_param_pkg::NUM_CH - 1)) begin
						ch <= 3'd0;
						op <= (op == 2'(fm_param_pkg::NUM_OP - 1)) ? 2'd0 : op + 2'd1;
					end else begin
						ch <= ch + 3'd1;
					end
				end
				default: state <= SEQ_WAIT;
			endcase
		end
	end

endmodule

//--- fm_tb.sv
// directed testbench of the fm register core
// host writes, slot records, global registers, timer A and write back-pressure
`timescale 1ns/1ps

module fm_tb;

	// about twice the summed length of all tests
	localparam int MAX_CYCLES  = 20000;
	localparam int SLOT_LIMIT  = 30;
	// value 1020 overflows after 4 ticks of 2 clocks plus load latency and margin
	localparam int TIMER_LIMIT = (1024 - 1020) * 2 + 8;

	logic                   clk;
	logic                   rst;
	logic [1:0]             addr;
	logic [7:0]             din;
	logic                   write;
	logic                   busy;
	logic                   irq;
	logic                   flag_a;
	logic                   flag_b;
	fm_reg_pkg::fm_global_t glob;
	fm_param_pkg::fm_slot_t slot;
	logic                   slot_valid;

	int seed;
	int cycles;
	int checks;
	int errors;
	int tests;
	int errs_at_start;

	fm_core_top fm_core_top_inst (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.din        (din),
		.write      (write),
		.busy       (busy),
		.irq        (irq),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.glob       (glob),
		.slot       (slot),
		.slot_valid (slot_valid)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d clocks without finishing", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	// one byte on the host port with write high for two clocks then low
	task automatic write_byte(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk);
		addr  <= a;
		din   <= d;
		write <= 1'b1;
		repeat (2) @(posedge clk);
		write <= 1'b0;
		@(posedge clk);
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (busy)
			@(negedge clk);
	endtask

	task automatic reg_write(input logic bank, input logic [7:0] sel, input logic [7:0] data);
		write_byte({bank, 1'b0}, sel);
		write_byte({bank, 1'b1}, data);
		wait_idle();
	endtask

	// next record of any slot
	task automatic skip_slot();
		@(negedge clk);
		while (!slot_valid)
			@(negedge clk);
	endtask

	task automatic wait_slot(input int ch, input int op);
		int   seen;
		logic found;
		seen  = 0;
		found = 1'b0;
		while (!found && seen < SLOT_LIMIT) begin
			@(negedge clk);
			if (slot_valid) begin
				seen++;
				if (slot.ch == ch && slot.op == op)
					found = 1'b1;
			end
		end
		if (!found) begin
			errors++;
			$display("slot of channel %0d operator %0d did not appear within %0d slots",
				ch, op, SLOT_LIMIT);
		end
	endtask

	task automatic idle_after_reset();
		@(negedge clk);
		check("busy", busy, 1'b0);
		check("irq", irq, 1'b0);
		check("flag_a", flag_a, 1'b0);
		check("flag_b", flag_b, 1'b0);
		check("slot_valid", slot_valid, 1'b0);
		check("glob", glob, 14'h0);
		finish_test("reset values");
	endtask

	task automatic operator_param_records();
		int         pch [4];
		int         pop [4];
		logic [7:0] tl_val [4];
		logic [7:0] dm_val [4];
		logic [7:0] sub;
		// pairs in slot order over both banks
		pch = '{0, 4, 5, 2};
		pop = '{0, 1, 2, 3};
		for (int i = 0; i < 4; i++) begin
			tl_val[i] = 8'($random(seed));
			dm_val[i] = 8'($random(seed));
			sub = 8'(pch[i] % 3);
			reg_write(pch[i] >= 3, fm_reg_pkg::REG_OP_TL + 8'(pop[i] * 4) + sub, tl_val[i]);
			reg_write(pch[i] >= 3, fm_reg_pkg::REG_OP_DT1MUL + 8'(pop[i] * 4) + sub,
				dm_val[i]);
		end
		// the record in flight may predate the writes
		skip_slot();
		for (int i = 0; i < 4; i++) begin
			wait_slot(pch[i], pop[i]);
			check("slot.tl", slot.tl, tl_val[i][6:0]);
			check("slot.dt1", slot.dt1, dm_val[i][6:4]);
			check("slot.mul", slot.mul, dm_val[i][3:0]);
		end
		finish_test("operator params");
	endtask

	task automatic fnum_block_records();
		logic [7:0] hi;
		logic [7:0] lo;
		hi = 8'($random(seed)) & 8'h3F;
		lo = 8'($random(seed));
		// channel 4 sits in bank 1 at offset 1
		reg_write(1'b1, fm_reg_pkg::REG_CH_FNUM_HI + 8'd1, hi);
		reg_write(1'b1, fm_reg_pkg::REG_CH_FNUM_LO + 8'd1, lo);
		skip_slot();
		for (int op = 0; op < 4; op++) begin
			wait_slot(4, op);
			check("slot.fnum", slot.fnum, {hi[2:0], lo});
			check("slot.block", slot.block, hi[5:3]);
		end
		finish_test("fnum and block");
	endtask

	task automatic keyon_and_globals();
		logic [7:0]             kon;
		logic [7:0]             pcm_hi;
		fm_reg_pkg::fm_global_t exp_glob;
		// code 6 is channel 5 with operators 0, 1 and 3 keyed
		kon = 8'hB6;
		reg_write(1'b0, fm_reg_pkg::REG_KON, kon);
		skip_slot();
		for (int op = 0; op < 4; op++) begin
			for (int ch = 0; ch < 6; ch++) begin
				wait_slot(ch, op);
				check("slot.keyon", slot.keyon, (ch == 5) ? kon[4 + op] : 1'b0);
			end
		end

		// LFO byte is seen on glob one clock after the write edge
		write_byte(2'b00, fm_reg_pkg::REG_LFO);
		@(posedge clk);
		addr  <= 2'b01;
		din   <= 8'h0D;
		write <= 1'b1;
		@(negedge clk);
		check("glob.lfo", {glob.lfo_en, glob.lfo_freq}, 4'h0);
		@(negedge clk);
		check("glob.lfo", {glob.lfo_en, glob.lfo_freq}, 4'hD);
		@(posedge clk);
		write <= 1'b0;
		@(posedge clk);

		pcm_hi = 8'($random(seed));
		reg_write(1'b0, fm_reg_pkg::REG_PCM, pcm_hi);
		reg_write(1'b0, fm_reg_pkg::REG_DACTEST, 8'h08);
		reg_write(1'b0, fm_reg_pkg::REG_PCM_EN, 8'h80);
		exp_glob.lfo_en   = 1'b1;
		exp_glob.lfo_freq = 3'd5;
		exp_glob.pcm      = {pcm_hi, 1'b1};
		exp_glob.pcm_en   = 1'b1;
		check("glob", glob, exp_glob);
		finish_test("keyon and globals");
	endtask

	task automatic timer_a_overflow();
		int n;
		reg_write(1'b0, fm_reg_pkg::REG_CLK_N2, 8'h00);
		// value_a = 1020
		reg_write(1'b0, fm_reg_pkg::REG_CLKA1, 8'hFF);
		reg_write(1'b0, fm_reg_pkg::REG_CLKA2, 8'h00);
		write_byte(2'b00, fm_reg_pkg::REG_TIMER);
		// irq_en_a and load_a
		@(posedge clk);
		addr  <= 2'b01;
		din   <= 8'h05;
		write <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!flag_a && n < TIMER_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!flag_a) begin
			errors++;
			$display("flag_a did not rise within %0d clocks of the timer load", TIMER_LIMIT);
		end
		check("flag_a", flag_a, 1'b1);
		check("irq", irq, 1'b1);
		@(posedge clk);
		write <= 1'b0;
		@(posedge clk);
		// clr_a with the timer stopped
		reg_write(1'b0, fm_reg_pkg::REG_TIMER, 8'h10);
		check("flag_a", flag_a, 1'b0);
		check("irq", irq, 1'b0);
		finish_test("timer A");
	endtask

	task automatic write_dropped_while_busy();
		logic [7:0] keep;
		logic [7:0] drop;
		keep = 8'($random(seed));
		drop = keep ^ 8'h7F;
		// TL of channel 1 operator 2
		write_byte(2'b00, fm_reg_pkg::REG_OP_TL + 8'd9);
		@(posedge clk);
		addr  <= 2'b01;
		din   <= keep;
		write <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		@(posedge clk);
		din   <= drop;
		write <= 1'b1;
		@(negedge clk);
		// second write edge lands while the first is still on the bus
		check("busy", busy, 1'b1);
		wait_idle();
		@(posedge clk);
		write <= 1'b0;
		skip_slot();
		wait_slot(1, 2);
		check("slot.tl", slot.tl, keep[6:0]);
		finish_test("write while busy");
	endtask

	initial begin
		seed          = 87354;
		cycles        = 0;
		checks        = 0;
		errors        = 0;
		tests         = 0;
		errs_at_start = 0;
		rst   <= 1'b1;
		addr  <= 2'b00;
		din   <= 8'h00;
		write <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		idle_after_reset();
		operator_param_records();
		fnum_block_records();
		keyon_and_globals();
		timer_a_overflow();
		write_dropped_while_busy();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- fm_timebase.sv
// prescaler tick generator of the fm core
// timers A and B with overflow flags and the interrupt line
`timescale 1ns/1ps

module fm_timebase (
	input  logic                       clk,
	input  logic                       rst,
	input  fm_reg_pkg::fm_timer_ctrl_t tctrl,
	output logic                       tick,
	output logic                       flag_a,
	output logic                       flag_b,
	output logic                       irq
);

	logic [2:0] presc_cnt;
	logic [2:0] presc_lim;
	logic [1:0] load_q;
	logic       run_a;
	logic       run_b;
	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [3:0] pre_b;
	logic       step_b;
	logic       ovf_a;
	logic       ovf_b;

	always_comb begin
		case (tctrl.presc)
			fm_reg_pkg::PRESC_3: presc_lim = 3'd2;
			fm_reg_pkg::PRESC_2: presc_lim = 3'd1;
			default:             presc_lim = 3'd5;
		endcase
	end

	// >= so that a smaller ratio takes effect at once
	always_ff @(posedge clk) begin
		if (rst) begin
			presc_cnt <= 3'd0;
			tick      <= 1'b0;
		end else begin
			tick      <= (presc_cnt >= presc_lim);
			presc_cnt <= (presc_cnt >= presc_lim) ? 3'd0 : presc_cnt + 3'd1;
		end
	end

	// a timer runs once its load bit has been set for a clock
	assign run_a  = tctrl.load_a && load_q[0];
	assign run_b  = tctrl.load_b && load_q[1];
	assign ovf_a  = tick && run_a && (cnt_a == 10'h3FF);
	assign step_b = tick && run_b && (pre_b == 4'hF);
	assign ovf_b  = step_b && (cnt_b == 8'hFF);

	always_ff @(posedge clk) begin
		if (rst) begin
			load_q <= 2'b00;
			cnt_a  <= 10'd0;
			cnt_b  <= 8'd0;
			pre_b  <= 4'd0;
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			load_q <= {tctrl.load_b, tctrl.load_a};

			// timer A
			if (tctrl.load_a && !load_q[0])
				cnt_a <= tctrl.value_a;
			else if (ovf_a)
				cnt_a <= tctrl.value_a;
			else if (tick && run_a)
				cnt_a <= cnt_a + 10'd1;

			// timer B, advanced every 16 ticks
			if (tctrl.load_b && !load_q[1]) begin
				cnt_b <= tctrl.value_b;
				pre_b <= 4'd0;
			end else begin
				if (tick && run_b)
					pre_b <= pre_b + 4'd1;
				if (ovf_b)
					cnt_b <= tctrl.value_b;
				else if (step_b)
					cnt_b <= cnt_b + 8'd1;
			end

			if (tctrl.clr_a)
				flag_a <= 1'b0;
			else if (ovf_a && tctrl.irq_en_a)
				flag_a <= 1'b1;

			if (tctrl.clr_b)
				flag_b <= 1'b0;
			else if (ovf_b && tctrl.irq_en_b)
				flag_b <= 1'b1;
		end
	end

	assign irq = flag_a | flag_b;

	a_tick_single: assert property (@(posedge clk) disable iff (rst) tick |=> !tick);

endmodule

//--- src.f
fm_reg_pkg.sv
fm_param_pkg.sv
fm_host_port.sv
fm_timebase.sv
fm_param_arbiter.sv
fm_param_ram.sv
fm_slot_seq.sv
fm_core_top.sv
fm_tb.sv
